//--- rtl/core.sv
package core;

   typedef logic [4:0] reg_idx_t;

   // Major opcodes of the RV32I base set.
   typedef enum logic [6:0] {
      L_OP    = 7'b0000011,
      I_OP    = 7'b0010011,
      AUI_OP  = 7'b0010111,
      S_OP    = 7'b0100011,
      RR_OP   = 7'b0110011,
      LUI_OP  = 7'b0110111,
      B_OP    = 7'b1100011,
      JALR_OP = 7'b1100111,
      JAL_OP  = 7'b1101111,
      E_OP    = 7'b1110011
   } opcode_e;

   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } rtype_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } itype_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } btype_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } utype_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } jtype_t;

   // One fetched word, read through whichever layout the opcode calls for.
   typedef union packed {
      rtype_t      rtype;
      itype_t      itype;
      stype_t      stype;
      btype_t      btype;
      utype_t      utype;
      jtype_t      jtype;
      logic [31:0] raw;
   } instruction_t;

   typedef enum logic [2:0] {
      NOP,
      R_FORMAT,
      I_FORMAT,
      S_FORMAT,
      B_FORMAT,
      U_FORMAT,
      J_FORMAT
   } format_e;

   localparam logic [1:0] SPECIAL_PRFX = 2'b00;
   localparam logic [1:0] ARITHM_PRFX  = 2'b01;
   localparam logic [1:0] BRANCH_PRFX  = 2'b10;

   // Class, alternate bit, funct3.
   typedef enum logic [5:0] {
      ALU_NOP   = {SPECIAL_PRFX, 1'b0, 3'b000},
      ALU_LUI   = {SPECIAL_PRFX, 1'b0, 3'b001},
      ALU_AUIPC = {SPECIAL_PRFX, 1'b0, 3'b010},
      ALU_JAL   = {SPECIAL_PRFX, 1'b0, 3'b011},
      ALU_JALR  = {SPECIAL_PRFX, 1'b0, 3'b100},
      ALU_ADD   = {ARITHM_PRFX, 1'b0, 3'b000},
      ALU_SUB   = {ARITHM_PRFX, 1'b1, 3'b000},
      ALU_SLL   = {ARITHM_PRFX, 1'b0, 3'b001},
      ALU_SLT   = {ARITHM_PRFX, 1'b0, 3'b010},
      ALU_SLTU  = {ARITHM_PRFX, 1'b0, 3'b011},
      ALU_XOR   = {ARITHM_PRFX, 1'b0, 3'b100},
      ALU_SRL   = {ARITHM_PRFX, 1'b0, 3'b101},
      ALU_SRA   = {ARITHM_PRFX, 1'b1, 3'b101},
      ALU_OR    = {ARITHM_PRFX, 1'b0, 3'b110},
      ALU_AND   = {ARITHM_PRFX, 1'b0, 3'b111},
      ALU_BEQ   = {BRANCH_PRFX, 1'b0, 3'b000},
      ALU_BNE   = {BRANCH_PRFX, 1'b0, 3'b001},
      ALU_BLT   = {BRANCH_PRFX, 1'b0, 3'b100},
      ALU_BGE   = {BRANCH_PRFX, 1'b0, 3'b101},
      ALU_BLTU  = {BRANCH_PRFX, 1'b0, 3'b110},
      ALU_BGEU  = {BRANCH_PRFX, 1'b0, 3'b111}
   } alu_op_e;

   localparam logic [1:0] NONE_PRFX  = 2'b00;
   localparam logic [1:0] LOAD_PRFX  = 2'b01;
   localparam logic [1:0] STORE_PRFX = 2'b10;

   typedef enum logic [4:0] {
      MEM_NOP = {NONE_PRFX, 3'b000},
      MEM_LB  = {LOAD_PRFX, 3'b000},
      MEM_LH  = {LOAD_PRFX, 3'b001},
      MEM_LW  = {LOAD_PRFX, 3'b010},
      MEM_LBU = {LOAD_PRFX, 3'b100},
      MEM_LHU = {LOAD_PRFX, 3'b101},
      MEM_SB  = {STORE_PRFX, 3'b000},
      MEM_SH  = {STORE_PRFX, 3'b001},
      MEM_SW  = {STORE_PRFX, 3'b010}
   } mem_op_e;

   typedef struct packed {
      logic [31:0]  pc;
      instruction_t instr;
      format_e      format;
      alu_op_e      alu_op;
      mem_op_e      mem_op;
      reg_idx_t     rs1;
      reg_idx_t     rs2;
      reg_idx_t     rd;
      logic [31:0]  rs1_data;
      logic [31:0]  rs2_data;
      logic [31:0]  imm;
      logic [31:0]  rd_res;       // Only meaningful on the write-back side.
      logic         rf_wr_en;
      logic         is_branch;
      logic         illegal;
   } pipeline_bus_t;

endpackage

//--- rtl/imm_generator.sv
`timescale 1ns/1ps

module imm_generator (
   input  core::instruction_t instr_i,
   input  core::format_e      format_i,
   output logic [31:0]        imm_o
);
   import core::*;

   logic [31:0] imm_i;
   logic [31:0] imm_s;
   logic [31:0] imm_b;
   logic [31:0] imm_u;
   logic [31:0] imm_j;

   assign imm_i = {{20{instr_i.itype.imm[11]}}, instr_i.itype.imm};

   assign imm_s = {{20{instr_i.stype.imm_hi[6]}}, instr_i.stype.imm_hi, instr_i.stype.imm_lo};

   // Branch offsets are in halfwords, bit 0 is always zero.
   assign imm_b = {{19{instr_i.btype.imm_12}},
                   instr_i.btype.imm_12,
                   instr_i.btype.imm_11,
                   instr_i.btype.imm_10_5,
                   instr_i.btype.imm_4_1,
                   1'b0};

   assign imm_u = {instr_i.utype.imm, 12'b0};

   assign imm_j = {{11{instr_i.jtype.imm_20}},
                   instr_i.jtype.imm_20,
                   instr_i.jtype.imm_19_12,
                   instr_i.jtype.imm_11,
                   instr_i.jtype.imm_10_1,
                   1'b0};

   always_comb begin
      case (format_i)
         I_FORMAT: imm_o = imm_i;
         S_FORMAT: imm_o = imm_s;
         B_FORMAT: imm_o = imm_b;
         U_FORMAT: imm_o = imm_u;
         J_FORMAT: imm_o = imm_j;
         default:  imm_o = '0;   // R-type and NOP carry no immediate.
      endcase
   end

endmodule

//--- rtl/regfile_2r1w.sv
`timescale 1ns/1ps

module regfile_2r1w #(
   parameter int NR_REGS = 32
) (
   input  logic           clk,
   input  logic           rst_n_i,
   input  core::reg_idx_t raddr_a_i,
   input  core::reg_idx_t raddr_b_i,
   input  logic           wen_i,
   input  core::reg_idx_t waddr_i,
   input  logic [31:0]    wdata_i,
   output logic [31:0]    rdata_a_o,
   output logic [31:0]    rdata_b_o
);
   import core::*;

   logic [31:0] regs [NR_REGS];
   logic        wr_ok;
   reg_idx_t    raddr [2];
   logic [31:0] rdata [2];

   // x0 and indices past the implemented range are never written.
   assign wr_ok = wen_i && (waddr_i != '0) && (int'(waddr_i) < NR_REGS);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NR_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign raddr[0]  = raddr_a_i;
   assign raddr[1]  = raddr_b_i;
   assign rdata_a_o = rdata[0];
   assign rdata_b_o = rdata[1];

   for (genvar p = 0; p < 2; p++) begin : g_read
      always_comb begin
         if (raddr[p] == '0 || int'(raddr[p]) >= NR_REGS)
            rdata[p] = '0;
         else if (wr_ok && waddr_i == raddr[p])
            rdata[p] = wdata_i;       // Write-through.
         else
            rdata[p] = regs[raddr[p]];
      end
   end

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder #(
   parameter int NR_REGS = 32
) (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic [31:0]         instruction_i,
   input  logic [31:0]         pc_i,
   input  core::pipeline_bus_t wb_bus_i,
   output core::pipeline_bus_t id_bus_o
);
   import core::*;

   instruction_t instr;
   format_e      fmt;
   alu_op_e      alu_op;
   mem_op_e      mem_op;
   reg_idx_t     rs1;
   reg_idx_t     rs2;
   reg_idx_t     rd;
   logic         wr_en;
   logic         is_branch;
   logic         illegal;
   logic         i_alt;
   logic [31:0]  imm;
   logic [31:0]  rs1_data;
   logic [31:0]  rs2_data;

   assign instr = instruction_t'(instruction_i);

   // Only SLLI and SRLI/SRAI use bit 30 as part of the operation.
   assign i_alt = (instr.itype.funct3 == 3'b001 || instr.itype.funct3 == 3'b101) ?
                  instr.itype.imm[10] : 1'b0;

   imm_generator im_gen (
      .instr_i  (instr),
      .format_i (fmt),
      .imm_o    (imm)
   );

   regfile_2r1w #(
      .NR_REGS (NR_REGS)
   ) rf (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .raddr_a_i (rs1),
      .raddr_b_i (rs2),
      .wen_i     (wb_bus_i.rf_wr_en),
      .waddr_i   (wb_bus_i.rd),
      .wdata_i   (wb_bus_i.rd_res),
      .rdata_a_o (rs1_data),
      .rdata_b_o (rs2_data)
   );

   always_comb begin : instr_decoder
      fmt       = NOP;
      alu_op    = ALU_NOP;
      mem_op    = MEM_NOP;
      rs1       = '0;
      rs2       = '0;
      rd        = '0;
      wr_en     = 1'b0;
      is_branch = 1'b0;
      illegal   = 1'b0;

      case (instr.raw[6:0])
         I_OP: begin
            fmt = I_FORMAT;
            rs1 = instr.itype.rs1;
            rd  = instr.itype.rd;
            // addi x0, x0, 0 is the canonical NOP.
            if (instr.itype.rs1 != '0 || instr.itype.rd != '0 || instr.itype.imm != '0) begin
               alu_op = alu_op_e'({ARITHM_PRFX, i_alt, instr.itype.funct3});
               wr_en  = 1'b1;
            end
         end
         RR_OP: begin
            fmt    = R_FORMAT;
            rs1    = instr.rtype.rs1;
            rs2    = instr.rtype.rs2;
            rd     = instr.rtype.rd;
            alu_op = alu_op_e'({ARITHM_PRFX, instr.rtype.funct7[5], instr.rtype.funct3});
            wr_en  = 1'b1;
         end
         L_OP: begin
            fmt    = I_FORMAT;
            rs1    = instr.itype.rs1;
            rd     = instr.itype.rd;
            mem_op = mem_op_e'({LOAD_PRFX, instr.itype.funct3});
            wr_en  = 1'b1;
         end
         S_OP: begin
            fmt    = S_FORMAT;
            rs1    = instr.stype.rs1;
            rs2    = instr.stype.rs2;
            mem_op = mem_op_e'({STORE_PRFX, instr.stype.funct3});
         end
         B_OP: begin
            fmt       = B_FORMAT;
            rs1       = instr.btype.rs1;
            rs2       = instr.btype.rs2;
            alu_op    = alu_op_e'({BRANCH_PRFX, 1'b0, instr.btype.funct3});
            is_branch = 1'b1;
         end
         LUI_OP, AUI_OP: begin
            fmt    = U_FORMAT;
            rd     = instr.utype.rd;
            alu_op = (instr.raw[6:0] == LUI_OP) ? ALU_LUI : ALU_AUIPC;
            wr_en  = 1'b1;
         end
         JAL_OP: begin
            fmt       = J_FORMAT;
            rd        = instr.jtype.rd;
            alu_op    = ALU_JAL;
            wr_en     = 1'b1;
            is_branch = 1'b1;
         end
         JALR_OP: begin
            fmt       = I_FORMAT;  // Offset is a plain 12-bit I immediate.
            rs1       = instr.itype.rs1;
            rd        = instr.itype.rd;
            alu_op    = ALU_JALR;
            wr_en     = 1'b1;
            is_branch = 1'b1;
         end
         E_OP: begin
            // SYSTEM words retire as no-ops.
         end
         default: illegal = 1'b1;
      endcase
   end

   always_comb begin
      id_bus_o.pc        = pc_i;
      id_bus_o.instr     = instr;
      id_bus_o.format    = fmt;
      id_bus_o.alu_op    = alu_op;
      id_bus_o.mem_op    = mem_op;
      id_bus_o.rs1       = rs1;
      id_bus_o.rs2       = rs2;
      id_bus_o.rd        = rd;
      id_bus_o.rs1_data  = rs1_data;
      id_bus_o.rs2_data  = rs2_data;
      id_bus_o.imm       = imm;
      id_bus_o.rd_res    = '0;        // Filled in by execute.
      id_bus_o.rf_wr_en  = wr_en;
      id_bus_o.is_branch = is_branch;
      id_bus_o.illegal   = illegal;
   end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
   parameter int NR_REGS = 32
) (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                instr_valid_i,
   input  logic [31:0]         instruction_i,
   input  logic [31:0]         pc_i,
   input  core::pipeline_bus_t wb_bus_i,
   output core::pipeline_bus_t id_bus_o,
   output logic                id_valid_o
);
   import core::*;

   pipeline_bus_t dec_bus;

   decoder #(
      .NR_REGS (NR_REGS)
   ) dec (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .instruction_i (instruction_i),
      .pc_i          (pc_i),
      .wb_bus_i      (wb_bus_i),
      .id_bus_o      (dec_bus)
   );

   // ID/EX register.
   // The bus is only reloaded on a strobe, so it holds between instructions.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         id_bus_o   <= '0;
         id_valid_o <= 1'b0;
      end else begin
         id_valid_o <= instr_valid_i;
         if (instr_valid_i) begin
            id_bus_o <= dec_bus;
         end
      end
   end

endmodule

//--- bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Mirror of the architectural registers, kept in step with every write-back.
logic [31:0] model_regs [32];

task automatic model_reset();
   for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
   end
endtask

function automatic logic [31:0] model_read(input logic [4:0] idx);
   return (idx == 5'd0) ? 32'h0 : model_regs[idx];
endfunction

function automatic bit opcode_is_known(input logic [6:0] op);
   case (op)
      L_OP, I_OP, AUI_OP, S_OP, RR_OP, LUI_OP, B_OP, JALR_OP, JAL_OP, E_OP: return 1'b1;
      default: return 1'b0;
   endcase
endfunction

// Expected ID bus for one word, straight from the RV32I field layouts.
function automatic pipeline_bus_t expected_bus(input logic [31:0] w, input logic [31:0] pc);
   pipeline_bus_t e;
   logic [2:0]    f3;
   logic          alt;
   e         = '0;
   f3        = w[14:12];
   alt       = (f3 == 3'b001 || f3 == 3'b101) ? w[30] : 1'b0;   // Shift immediates only.
   e.pc      = pc;
   e.instr   = w;
   e.illegal = !opcode_is_known(w[6:0]);
   if (w[6:0] inside {I_OP, RR_OP, L_OP, S_OP, B_OP, JALR_OP}) begin
      e.rs1 = w[19:15];
   end
   if (w[6:0] inside {RR_OP, S_OP, B_OP}) begin
      e.rs2 = w[24:20];
   end
   if (w[6:0] inside {I_OP, RR_OP, L_OP, LUI_OP, AUI_OP, JAL_OP, JALR_OP}) begin
      e.rd       = w[11:7];
      e.rf_wr_en = 1'b1;
   end
   e.is_branch = w[6:0] inside {B_OP, JAL_OP, JALR_OP};
   case (w[6:0])
      I_OP: begin
         e.format = I_FORMAT;
         if (w[31:15] == '0 && w[11:7] == '0) begin
            e.rf_wr_en = 1'b0;   // addi x0, x0, 0.
         end else begin
            e.alu_op = alu_op_e'({ARITHM_PRFX, alt, f3});
         end
      end
      RR_OP: begin
         e.format = R_FORMAT;
         e.alu_op = alu_op_e'({ARITHM_PRFX, w[30], f3});
      end
      L_OP: begin
         e.format = I_FORMAT;
         e.mem_op = mem_op_e'({LOAD_PRFX, f3});
      end
      S_OP: begin
         e.format = S_FORMAT;
         e.mem_op = mem_op_e'({STORE_PRFX, f3});
      end
      B_OP: begin
         e.format = B_FORMAT;
         e.alu_op = alu_op_e'({BRANCH_PRFX, 1'b0, f3});
      end
      LUI_OP: begin
         e.format = U_FORMAT;
         e.alu_op = ALU_LUI;
      end
      AUI_OP: begin
         e.format = U_FORMAT;
         e.alu_op = ALU_AUIPC;
      end
      JAL_OP: begin
         e.format = J_FORMAT;
         e.alu_op = ALU_JAL;
      end
      JALR_OP: begin
         e.format = I_FORMAT;
         e.alu_op = ALU_JALR;
      end
      default: ;
   endcase
   case (e.format)
      I_FORMAT: e.imm = {{20{w[31]}}, w[31:20]};
      S_FORMAT: e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      B_FORMAT: e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      U_FORMAT: e.imm = {w[31:12], 12'h000};
      J_FORMAT: e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:  e.imm = '0;
   endcase
   e.rs1_data = model_read(e.rs1);
   e.rs2_data = model_read(e.rs2);
   return e;
endfunction

`endif

//--- bench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
   import core::*;

   localparam int N_INSTR    = 300;
   localparam int MAX_CYCLES = 6 * N_INSTR * 3 + 600;

   logic          clk;
   logic          rst_n_i;
   logic          instr_valid_i;
   logic [31:0]   instruction_i;
   logic [31:0]   pc_i;
   pipeline_bus_t wb_bus_i;
   pipeline_bus_t id_bus_o;
   logic          id_valid_o;

   logic [31:0] seed    = 32'h7805;
   logic [31:0] next_pc = 32'h0000_1000;
   int          cycles  = 0;
   int          checks  = 0;
   int          errors  = 0;
   int          test_errors = 0;

   opcode_e legal_ops [10] = '{L_OP, I_OP, AUI_OP, S_OP, RR_OP,
                               LUI_OP, B_OP, JALR_OP, JAL_OP, E_OP};
   opcode_e imm_ops [8] = '{I_OP, L_OP, S_OP, B_OP, LUI_OP, AUI_OP, JAL_OP, JALR_OP};

   `include "decode_model.svh"

   decode_stage #(
      .NR_REGS (32)
   ) uut (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .instr_valid_i (instr_valid_i),
      .instruction_i (instruction_i),
      .pc_i          (pc_i),
      .wb_bus_i      (wb_bus_i),
      .id_bus_o      (id_bus_o),
      .id_valid_o    (id_valid_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Random fields with the opcode forced.
   function automatic logic [31:0] rand_word(input logic [6:0] op);
      logic [31:0] r;
      r = next_rand();
      return {r[31:7], op};
   endfunction

   function automatic logic [6:0] undefined_opcode();
      logic [31:0] r;
      r = next_rand();
      while (opcode_is_known(r[22:16])) begin
         r = next_rand();
      end
      return r[22:16];
   endfunction

   task automatic compare_field(input string name, input logic [31:0] want,
                                input logic [31:0] got);
      checks++;
      if (want !== got) begin
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_bus(input pipeline_bus_t want);
      compare_field("pc", want.pc, id_bus_o.pc);
      compare_field("instr", want.instr, id_bus_o.instr);
      compare_field("format", want.format, id_bus_o.format);
      compare_field("alu_op", want.alu_op, id_bus_o.alu_op);
      compare_field("mem_op", want.mem_op, id_bus_o.mem_op);
      compare_field("rs1", want.rs1, id_bus_o.rs1);
      compare_field("rs2", want.rs2, id_bus_o.rs2);
      compare_field("rd", want.rd, id_bus_o.rd);
      compare_field("rs1_data", want.rs1_data, id_bus_o.rs1_data);
      compare_field("rs2_data", want.rs2_data, id_bus_o.rs2_data);
      compare_field("imm", want.imm, id_bus_o.imm);
      compare_field("rd_res", want.rd_res, id_bus_o.rd_res);
      compare_field("rf_wr_en", want.rf_wr_en, id_bus_o.rf_wr_en);
      compare_field("is_branch", want.is_branch, id_bus_o.is_branch);
      compare_field("illegal", want.illegal, id_bus_o.illegal);
   endtask

   // The ID/EX register answers exactly one cycle after the strobe.
   task automatic wait_and_check(input pipeline_bus_t want);
      @(negedge clk);
      checks++;
      if (!id_valid_o) begin
         $display("ERROR at %0t: id_valid_o did not rise one cycle after a strobe.", $time);
         errors++;
         test_errors++;
      end else begin
         check_bus(want);
      end
   endtask

   // One strobe, optionally with a write-back in the same cycle.
   task automatic issue(input logic [31:0] w, input logic wb_en, input reg_idx_t wb_rd,
                        input logic [31:0] wb_data);
      pipeline_bus_t wb;
      pipeline_bus_t want;
      wb          = '0;
      wb.rd       = wb_rd;
      wb.rd_res   = wb_data;
      wb.rf_wr_en = wb_en;
      @(posedge clk);
      instr_valid_i <= 1'b1;
      instruction_i <= w;
      pc_i          <= next_pc;
      wb_bus_i      <= wb;
      if (wb_en && wb_rd != '0) begin
         model_regs[wb_rd] = wb_data;   // Lands at the same edge as the decode.
      end
      want    = expected_bus(w, next_pc);
      next_pc = next_pc + 32'd4;
      @(posedge clk);
      instr_valid_i <= 1'b0;
      wb_bus_i      <= '0;
      wait_and_check(want);
   endtask

   task automatic check_hold(input int n);
      pipeline_bus_t held;
      held = id_bus_o;
      repeat (n) begin
         @(posedge clk);
         instruction_i <= next_rand();   // Inputs move while the strobe stays low.
         pc_i          <= next_rand();
         @(negedge clk);
         compare_field("id_valid_o", 32'd0, {31'd0, id_valid_o});
         checks++;
         if (id_bus_o !== held) begin
            $display("CHECK FAILED at %0t: id_bus_o expected %h, got %h", $time, held, id_bus_o);
            errors++;
            test_errors++;
         end
      end
   endtask

   task automatic finish_test(input string name);
      $display("Test %-14s done, %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] w;
      reg_idx_t    idx;
      reg_idx_t    last_rd;
      rst_n_i       = 1'b0;
      instr_valid_i = 1'b0;
      instruction_i = '0;
      pc_i          = '0;
      wb_bus_i      = '0;
      model_reset();
      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;

      repeat (3) begin
         @(negedge clk);
         compare_field("id_valid_o", 32'd0, {31'd0, id_valid_o});
      end
      checks++;
      if (id_bus_o !== '0) begin
         $display("CHECK FAILED at %0t: id_bus_o expected 0, got %h", $time, id_bus_o);
         errors++;
         test_errors++;
      end
      for (int i = 0; i < 32; i++) begin
         idx = i[4:0];
         issue({7'd0, idx, idx, 3'b000, 5'd1, RR_OP}, 1'b0, '0, '0);
      end
      finish_test("reset");

      for (int i = 0; i < N_INSTR; i++) begin
         r = next_rand();
         issue(rand_word(legal_ops[r[31:16] % 10]), 1'b0, '0, '0);
      end
      finish_test("fields");

      for (int i = 0; i < N_INSTR; i++) begin
         r = next_rand();
         w = rand_word(imm_ops[r[18:16]]);
         w[31] = i[0];
         issue(w, 1'b0, '0, '0);
      end
      finish_test("immediates");

      last_rd = '0;
      for (int i = 0; i < N_INSTR; i++) begin
         r   = next_rand();
         idx = (i % 8 == 0) ? 5'd0 : r[20:16];
         w   = rand_word(RR_OP);
         w[24:20] = last_rd;   // Read back the previous write.
         issue(w, 1'b1, idx, next_rand());
         last_rd = idx;
      end
      finish_test("regfile");

      for (int i = 0; i < N_INSTR; i++) begin
         r   = next_rand();
         idx = r[20:16] | 5'd1;
         w   = rand_word(i[0] ? I_OP : RR_OP);
         w[19:15] = idx;
         issue(w, 1'b1, idx, next_rand());
      end
      finish_test("write-through");

      for (int i = 0; i < N_INSTR; i++) begin
         case (i % 3)
            0:       w = 32'h0000_0013;
            1:       w = rand_word(E_OP);
            default: w = rand_word(undefined_opcode());
         endcase
         issue(w, 1'b0, '0, '0);
         check_hold(2);
      end
      finish_test("nop/illegal");

      $display("Totals: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+bench
rtl/core.sv
rtl/imm_generator.sv
rtl/regfile_2r1w.sv
rtl/decoder.sv
rtl/decode_stage.sv
bench/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - rtl/core.sv
  - files:
      - rtl/imm_generator.sv
      - rtl/regfile_2r1w.sv
      - rtl/decoder.sv
      - rtl/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_decode_stage.sv
